//--- hw/line_proc_pkg.sv
// Shared widths, register map, control codes and data constants for the line processor
`default_nettype none

package line_proc_pkg;

  // Host channel widths
  localparam int unsigned CL_ADDR_W = 42;
  localparam int unsigned CL_DATA_W = 512;

  // Word view of one line
  localparam int unsigned WORD_W         = 32;
  localparam int unsigned WORDS_PER_LINE = 16;
  localparam int unsigned WORD_ADD       = 10;

  // Register port
  localparam int unsigned CSR_ADDR_W = 2;
  localparam int unsigned CSR_DATA_W = 64;
  localparam int unsigned CTRL_W     = 32;

  // Register offsets
  localparam logic [CSR_ADDR_W-1:0] REG_CONTROL = 2'd0;
  localparam logic [CSR_ADDR_W-1:0] REG_SRC     = 2'd1;
  localparam logic [CSR_ADDR_W-1:0] REG_DST     = 2'd2;
  localparam logic [CSR_ADDR_W-1:0] REG_DSM     = 2'd3;

  // Values software writes to the control register
  localparam logic [CTRL_W-1:0] CTRL_START = 32'd1;
  localparam logic [CTRL_W-1:0] CTRL_STOP  = 32'd2;

  // Completion line written to the status area
  localparam logic [CL_DATA_W-1:0] DONE_FLAG = 512'd1;

endpackage

`default_nettype wire

//--- hw/job_cfg_if.sv
// Job settings bus driven by the register block and read by the requestor
`timescale 1ns/1ps
`default_nettype none

interface job_cfg_if;

  logic [line_proc_pkg::CTRL_W-1:0]    control;
  logic [line_proc_pkg::CL_ADDR_W-1:0] src_addr;
  logic [line_proc_pkg::CL_ADDR_W-1:0] dst_addr;
  logic [line_proc_pkg::CL_ADDR_W-1:0] dsm_base;

  // Register block side
  modport csr (
    output control,
    output src_addr,
    output dst_addr,
    output dsm_base
  );

  // Requestor side
  modport req (
    input control,
    input src_addr,
    input dst_addr,
    input dsm_base
  );

endinterface

`default_nettype wire

//--- hw/line_csr.sv
// Register block for job control and line addresses, written and read over a strobe port
`timescale 1ns/1ps
`default_nettype none

module line_csr
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 csr_wr,
  input  logic [line_proc_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_wdata,
  output logic [line_proc_pkg::CSR_DATA_W-1:0] csr_rdata,
  job_cfg_if.csr                               cfg
);

  logic [line_proc_pkg::CTRL_W-1:0]    control_q;
  logic [line_proc_pkg::CL_ADDR_W-1:0] src_q;
  logic [line_proc_pkg::CL_ADDR_W-1:0] dst_q;
  logic [line_proc_pkg::CL_ADDR_W-1:0] dsm_q;

  // Write decode, values land on the next edge
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      control_q <= '0;
      src_q     <= '0;
      dst_q     <= '0;
      dsm_q     <= '0;
    end
    else if (csr_wr)
    begin
      case (csr_addr)
        line_proc_pkg::REG_CONTROL: control_q <= csr_wdata[line_proc_pkg::CTRL_W-1:0];
        line_proc_pkg::REG_SRC:     src_q     <= csr_wdata[line_proc_pkg::CL_ADDR_W-1:0];
        line_proc_pkg::REG_DST:     dst_q     <= csr_wdata[line_proc_pkg::CL_ADDR_W-1:0];
        line_proc_pkg::REG_DSM:     dsm_q     <= csr_wdata[line_proc_pkg::CL_ADDR_W-1:0];
      endcase
    end
  end

  // Readback, zero-extended to the port width
  always_comb
  begin
    case (csr_addr)
      line_proc_pkg::REG_CONTROL:
        csr_rdata = {{(line_proc_pkg::CSR_DATA_W - line_proc_pkg::CTRL_W){1'b0}}, control_q};
      line_proc_pkg::REG_SRC:
        csr_rdata = {{(line_proc_pkg::CSR_DATA_W - line_proc_pkg::CL_ADDR_W){1'b0}}, src_q};
      line_proc_pkg::REG_DST:
        csr_rdata = {{(line_proc_pkg::CSR_DATA_W - line_proc_pkg::CL_ADDR_W){1'b0}}, dst_q};
      line_proc_pkg::REG_DSM:
        csr_rdata = {{(line_proc_pkg::CSR_DATA_W - line_proc_pkg::CL_ADDR_W){1'b0}}, dsm_q};
      default:
        csr_rdata = '0;
    endcase
  end

  // Job settings out to the requestor
  assign cfg.control  = control_q;
  assign cfg.src_addr = src_q;
  assign cfg.dst_addr = dst_q;
  assign cfg.dsm_base = dsm_q;

endmodule

`default_nettype wire

//--- hw/line_requestor.sv
// Job FSM that reads one source line, adds a constant per word and writes result and status
`timescale 1ns/1ps
`default_nettype none

module line_requestor
(
  input  logic                                clk,
  input  logic                                reset,
  input  logic                                rd_almfull,
  input  logic                                rd_rsp_valid,
  input  logic [line_proc_pkg::CL_DATA_W-1:0] rd_rsp_data,
  input  logic                                wr_almfull,
  output logic                                rd_req_valid,
  output logic [line_proc_pkg::CL_ADDR_W-1:0] rd_req_addr,
  output logic                                wr_req_valid,
  output logic [line_proc_pkg::CL_ADDR_W-1:0] wr_req_addr,
  output logic [line_proc_pkg::CL_DATA_W-1:0] wr_req_data,
  job_cfg_if.req                              cfg
);

  typedef enum logic [2:0]
  {
    ST_IDLE,
    ST_READ,
    ST_WAIT,
    ST_WRITE,
    ST_FINISH,
    ST_DONE
  } state_t;

  state_t state;

  // Transformed line, held until the result write goes out
  logic [line_proc_pkg::CL_DATA_W-1:0] line_q;

  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      state <= ST_IDLE;
    end
    else
    begin
      case (state)
        ST_IDLE:
          if (cfg.control == line_proc_pkg::CTRL_START)
          begin
            state <= ST_READ;
          end
        ST_READ:
          if (!rd_almfull)
          begin
            state <= ST_WAIT;
          end
        ST_WAIT:
          if (rd_rsp_valid)
          begin
            state <= ST_WRITE;
          end
        ST_WRITE:
          if (!wr_almfull)
          begin
            state <= ST_FINISH;
          end
        ST_FINISH:
          if (!wr_almfull)
          begin
            state <= ST_DONE;
          end
        ST_DONE:
          // Wait here for software to acknowledge
          if (cfg.control == line_proc_pkg::CTRL_STOP)
          begin
            state <= ST_IDLE;
          end
        default:
          state <= ST_IDLE;
      endcase
    end
  end

  // Each word wraps modulo 2^32
  always_ff @(posedge clk)
  begin
    if (rd_rsp_valid && (state == ST_WAIT))
    begin
      for (int i = 0; i < line_proc_pkg::WORDS_PER_LINE; i++)
      begin
        line_q[i*line_proc_pkg::WORD_W +: line_proc_pkg::WORD_W] <=
          rd_rsp_data[i*line_proc_pkg::WORD_W +: line_proc_pkg::WORD_W] +
          line_proc_pkg::WORD_W'(line_proc_pkg::WORD_ADD);
      end
    end
  end

  // Read request, one pulse per job
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      rd_req_valid <= 1'b0;
    end
    else
    begin
      rd_req_valid <= (state == ST_READ) && !rd_almfull;
    end
    rd_req_addr <= cfg.src_addr;
  end

  // Result write first, then the completion flag to the status area
  always_ff @(posedge clk)
  begin
    if (reset)
    begin
      wr_req_valid <= 1'b0;
    end
    else
    begin
      wr_req_valid <= ((state == ST_WRITE) || (state == ST_FINISH)) && !wr_almfull;
    end
    if (state == ST_FINISH)
    begin
      wr_req_addr <= cfg.dsm_base + line_proc_pkg::CL_ADDR_W'(1);
      wr_req_data <= line_proc_pkg::DONE_FLAG;
    end
    else
    begin
      wr_req_addr <= cfg.dst_addr;
      wr_req_data <= line_q;
    end
  end

endmodule

`default_nettype wire

//--- hw/line_engine.sv
// Top level of the line processor, exposing the register port and host channel as plain ports
`timescale 1ns/1ps
`default_nettype none

module line_engine
(
  input  logic                                 clk,
  input  logic                                 reset,
  // Register port
  input  logic                                 csr_wr,
  input  logic [line_proc_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_wdata,
  output logic [line_proc_pkg::CSR_DATA_W-1:0] csr_rdata,
  // Read channel
  input  logic                                 rd_almfull,
  output logic                                 rd_req_valid,
  output logic [line_proc_pkg::CL_ADDR_W-1:0]  rd_req_addr,
  input  logic                                 rd_rsp_valid,
  input  logic [line_proc_pkg::CL_DATA_W-1:0]  rd_rsp_data,
  // Write channel
  input  logic                                 wr_almfull,
  output logic                                 wr_req_valid,
  output logic [line_proc_pkg::CL_ADDR_W-1:0]  wr_req_addr,
  output logic [line_proc_pkg::CL_DATA_W-1:0]  wr_req_data
);

  job_cfg_if cfg ();

  line_csr u_csr
  (
    .clk       (clk),
    .reset     (reset),
    .csr_wr    (csr_wr),
    .csr_addr  (csr_addr),
    .csr_wdata (csr_wdata),
    .csr_rdata (csr_rdata),
    .cfg       (cfg.csr)
  );

  line_requestor u_requestor
  (
    .clk          (clk),
    .reset        (reset),
    .rd_almfull   (rd_almfull),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .wr_almfull   (wr_almfull),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .wr_req_valid (wr_req_valid),
    .wr_req_addr  (wr_req_addr),
    .wr_req_data  (wr_req_data),
    .cfg          (cfg.req)
  );

endmodule

`default_nettype wire

//--- dv/line_engine_props.sv
// Channel and reset assertions, bound into the requestor
`timescale 1ns/1ps
`default_nettype none

module line_engine_props
(
  input logic       clk,
  input logic       reset,
  input logic       rd_almfull,
  input logic       wr_almfull,
  input logic       rd_req_valid,
  input logic       wr_req_valid,
  input logic [2:0] state
);

  // Encoding of the idle state in the requestor FSM
  localparam logic [2:0] IDLE_STATE = 3'd0;

  // Set once the current job has read its line, cleared back in idle
  logic read_issued;

  always_ff @(posedge clk)
  begin
    if (reset || (state == IDLE_STATE))
      read_issued <= 1'b0;
    else if (rd_req_valid)
      read_issued <= 1'b1;
  end

  a_rd_almfull: assert property (@(posedge clk) disable iff (reset)
    rd_req_valid |-> !$past(rd_almfull))
    else $error("Read request sent while read almost-full was high");

  a_wr_almfull: assert property (@(posedge clk) disable iff (reset)
    wr_req_valid |-> !$past(wr_almfull))
    else $error("Write request sent while write almost-full was high");

  a_reset_quiet: assert property (@(posedge clk)
    $past(reset) |-> (!rd_req_valid && !wr_req_valid))
    else $error("Request valid during reset");

  a_one_read: assert property (@(posedge clk) disable iff (reset)
    rd_req_valid |-> !read_issued)
    else $error("More than one read request in a job");

endmodule

bind line_requestor line_engine_props u_props
(
  .clk          (clk),
  .reset        (reset),
  .rd_almfull   (rd_almfull),
  .wr_almfull   (wr_almfull),
  .rd_req_valid (rd_req_valid),
  .wr_req_valid (wr_req_valid),
  .state        (state)
);

`default_nettype wire

//--- dv/line_engine_checker.sv
// Checker beside the DUT that models register readback and the expected requests of each job
`timescale 1ns/1ps
`default_nettype none

module line_engine_checker
(
  input  logic                                 clk,
  input  logic                                 reset,
  input  logic                                 csr_wr,
  input  logic [line_proc_pkg::CSR_ADDR_W-1:0] csr_addr,
  input  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_wdata,
  input  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_rdata,
  input  logic                                 rd_req_valid,
  input  logic [line_proc_pkg::CL_ADDR_W-1:0]  rd_req_addr,
  input  logic                                 rd_rsp_valid,
  input  logic [line_proc_pkg::CL_DATA_W-1:0]  rd_rsp_data,
  input  logic                                 wr_req_valid,
  input  logic [line_proc_pkg::CL_ADDR_W-1:0]  wr_req_addr,
  input  logic [line_proc_pkg::CL_DATA_W-1:0]  wr_req_data,
  output int                                   error_count,
  output int                                   jobs_done
);

  // Register model, already truncated to the readback form
  logic [63:0]  regs [4];
  logic [511:0] exp_line;
  logic [41:0]  exp_dsm;
  bit           rsp_seen;
  int           rd_cnt;
  int           wr_cnt;

  function automatic logic [511:0] add_to_words(input logic [511:0] line);
    logic [511:0] res;
    for (int i = 0; i < 16; i++)
    begin
      res[i*32 +: 32] = line[i*32 +: 32] + 32'd10;
    end
    return res;
  endfunction

  task automatic compare(input string name, input logic [511:0] exp, input logic [511:0] act);
    if (exp !== act)
    begin
      $display("FAILED %s expected %h actual %h", name, exp, act);
      error_count++;
    end
  endtask

  initial
  begin
    error_count = 0;
    jobs_done   = 0;
    rd_cnt      = 0;
    wr_cnt      = 0;
    rsp_seen    = 0;
    for (int i = 0; i < 4; i++)
      regs[i] = '0;
  end

  always @(posedge clk)
  begin
    if (!reset)
    begin
      compare("readback", 512'(regs[csr_addr]), 512'(csr_rdata));
      if (csr_wr)
      begin
        if (csr_addr == line_proc_pkg::REG_CONTROL)
          regs[0] = {32'd0, csr_wdata[31:0]};
        else
          regs[csr_addr] = {22'd0, csr_wdata[41:0]};
        if (csr_addr == line_proc_pkg::REG_CONTROL && csr_wdata[31:0] == 32'd1)
        begin
          rd_cnt   = 0;
          wr_cnt   = 0;
          rsp_seen = 0;
        end
      end
      if (rd_req_valid)
      begin
        rd_cnt++;
        if (rd_cnt > 1)
        begin
          $display("Extra read request issued within one job");
          error_count++;
        end
        compare("read_addr", 512'(regs[1][41:0]), 512'(rd_req_addr));
      end
      if (rd_rsp_valid)
      begin
        exp_line = add_to_words(rd_rsp_data);
        rsp_seen = 1;
      end
      if (wr_req_valid)
      begin
        wr_cnt++;
        if (wr_cnt == 1)
        begin
          if (!rsp_seen)
          begin
            $display("Result write issued before the read response");
            error_count++;
          end
          compare("result_addr", 512'(regs[2][41:0]), 512'(wr_req_addr));
          compare("result_data", exp_line, wr_req_data);
        end
        else if (wr_cnt == 2)
        begin
          exp_dsm = regs[3][41:0] + 42'd1;
          compare("status_addr", 512'(exp_dsm), 512'(wr_req_addr));
          compare("status_data", 512'd1, wr_req_data);
          jobs_done++;
        end
        else
        begin
          $display("Extra write request issued within one job");
          error_count++;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- dv/tb_line_engine.sv
// Testbench top for the line engine with clock, reset, host memory model and random job stimulus
`timescale 1ns/1ps
`default_nettype none

module tb_line_engine;

  localparam int NUM_JOBS       = 20;
  localparam int CYCLES_PER_JOB = 200;
  localparam int RESET_CYCLES   = 16;
  localparam int MAX_CYCLES     = NUM_JOBS * CYCLES_PER_JOB + RESET_CYCLES;

  logic                                 clk = 1'b0;
  logic                                 reset;
  logic                                 csr_wr;
  logic [line_proc_pkg::CSR_ADDR_W-1:0] csr_addr;
  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_wdata;
  logic [line_proc_pkg::CSR_DATA_W-1:0] csr_rdata;
  logic                                 rd_almfull;
  logic                                 rd_req_valid;
  logic [line_proc_pkg::CL_ADDR_W-1:0]  rd_req_addr;
  logic                                 rd_rsp_valid;
  logic [line_proc_pkg::CL_DATA_W-1:0]  rd_rsp_data;
  logic                                 wr_almfull;
  logic                                 wr_req_valid;
  logic [line_proc_pkg::CL_ADDR_W-1:0]  wr_req_addr;
  logic [line_proc_pkg::CL_DATA_W-1:0]  wr_req_data;

  integer seed = 32'haf41;
  int     cycles = 0;
  int     wr_seen = 0;
  int     wr_base;
  int     error_count;
  int     jobs_done;

  line_engine dut (.*);

  line_engine_checker u_checker
  (
    .clk          (clk),
    .reset        (reset),
    .csr_wr       (csr_wr),
    .csr_addr     (csr_addr),
    .csr_wdata    (csr_wdata),
    .csr_rdata    (csr_rdata),
    .rd_req_valid (rd_req_valid),
    .rd_req_addr  (rd_req_addr),
    .rd_rsp_valid (rd_rsp_valid),
    .rd_rsp_data  (rd_rsp_data),
    .wr_req_valid (wr_req_valid),
    .wr_req_addr  (wr_req_addr),
    .wr_req_data  (wr_req_data),
    .error_count  (error_count),
    .jobs_done    (jobs_done)
  );

  initial
  begin
    forever #20 clk = ~clk;
  end

  // Register write lasting one cycle, then a random readback address
  task automatic write_reg(input logic [1:0] addr, input logic [63:0] data);
    @(negedge clk);
    csr_wr    = 1'b1;
    csr_addr  = addr;
    csr_wdata = data;
    @(negedge clk);
    csr_wr    = 1'b0;
    csr_addr  = line_proc_pkg::CSR_ADDR_W'($random(seed));
  endtask

  // Host memory answers each read after 1 to 8 cycles
  initial
  begin
    int delay;
    forever
    begin
      @(posedge clk);
      if (rd_req_valid)
      begin
        delay = 1 + ($unsigned($random(seed)) % 8);
        repeat (delay) @(negedge clk);
        rd_rsp_valid = 1'b1;
        for (int i = 0; i < 16; i++)
        begin
          rd_rsp_data[i*32 +: 32] = $random(seed);
        end
        @(negedge clk);
        rd_rsp_valid = 1'b0;
      end
    end
  end

  // Almost-full levels flip now and then, giving random stretches
  initial
  begin
    forever
    begin
      @(negedge clk);
      if (($random(seed) & 7) == 0)
        rd_almfull = ~rd_almfull;
      if (($random(seed) & 7) == 0)
        wr_almfull = ~wr_almfull;
    end
  end

  always @(posedge clk)
  begin
    if (wr_req_valid)
      wr_seen <= wr_seen + 1;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES)
    begin
      $display("Timeout after %0d cycles, a job did not complete", cycles);
      $display("Testbench failed");
      $finish;
    end
  end

  initial
  begin
    reset        = 1'b1;
    csr_wr       = 1'b0;
    csr_addr     = '0;
    csr_wdata    = '0;
    rd_almfull   = 1'b0;
    wr_almfull   = 1'b0;
    rd_rsp_valid = 1'b0;
    rd_rsp_data  = '0;
    repeat (RESET_CYCLES) @(negedge clk);
    reset = 1'b0;
    for (int job = 0; job < NUM_JOBS; job++)
    begin
      write_reg(line_proc_pkg::REG_SRC, {$random(seed), $random(seed)});
      write_reg(line_proc_pkg::REG_DST, {$random(seed), $random(seed)});
      write_reg(line_proc_pkg::REG_DSM, {$random(seed), $random(seed)});
      wr_base = wr_seen;
      write_reg(line_proc_pkg::REG_CONTROL, 64'(line_proc_pkg::CTRL_START));
      wait (wr_seen >= wr_base + 2);
      // Quiet stretch in done, where stray requests would show up
      repeat (10) @(negedge clk);
      write_reg(line_proc_pkg::REG_CONTROL, 64'(line_proc_pkg::CTRL_STOP));
      repeat (4) @(negedge clk);
    end
    repeat (20) @(negedge clk);
    $display("Errors: %0d, jobs completed: %0d of %0d", error_count, jobs_done, NUM_JOBS);
    if (error_count == 0 && jobs_done == NUM_JOBS)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- line_engine.f
hw/line_proc_pkg.sv
hw/job_cfg_if.sv
hw/line_csr.sv
hw/line_requestor.sv
hw/line_engine.sv
dv/line_engine_props.sv
dv/line_engine_checker.sv
dv/tb_line_engine.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the line engine testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f line_engine.f \
  --top-module tb_line_engine -o sim_line_engine

out=$(./obj_dir/sim_line_engine)
echo "$out"

if echo "$out" | grep -qx "Testbench passed"; then
  exit 0
else
  exit 1
fi
